//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

	localparam int unsigned ADDR_WIDTH = 32;
	localparam int unsigned LINE_BYTES = 16;
	localparam int unsigned OFFSET_WIDTH = $clog2(LINE_BYTES);

	typedef logic [ADDR_WIDTH-1:0] addr_t; // byte address
	typedef logic [LINE_BYTES*8-1:0] line_t; // one memory line
	typedef logic [LINE_BYTES-1:0] mask_t; // byte enables of a line

	// everything from here up is memory mapped I/O
	localparam addr_t IO_BASE_ADDR = 32'h8000_0000;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_ISSUE, // waiting for the memory to be free
		CTRL_BUSY
	} ctrl_state_t;

	typedef enum logic {
		MEM_IDLE,
		MEM_WAITING // access delay, then response
	} mem_state_t;

endpackage

`default_nettype wire

//--- source/request_queue.sv
`timescale 1ns/1ps
`default_nettype none

module request_queue import mem_pkg::*; #(
	parameter int unsigned QUEUE_DEPTH = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic push,
	input wire logic push_write,
	input wire addr_t push_address,
	input wire mask_t push_mask,
	input wire line_t push_data,
	input wire logic pop,
	output logic empty,
	output logic ready,
	output logic head_write,
	output addr_t head_address,
	output mask_t head_mask,
	output line_t head_data
);

	localparam int unsigned PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int unsigned COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

	logic entry_write [QUEUE_DEPTH];
	addr_t entry_address [QUEUE_DEPTH];
	mask_t entry_mask [QUEUE_DEPTH];
	line_t entry_data [QUEUE_DEPTH];

	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic push_ok;
	logic pop_ok;

	assign empty = (count == '0);
	assign ready = (count != COUNT_WIDTH'(QUEUE_DEPTH));
	assign push_ok = push & ready; // client honours ready anyway
	assign pop_ok = pop & ~empty;

	assign head_write = entry_write[rd_ptr];
	assign head_address = entry_address[rd_ptr];
	assign head_mask = entry_mask[rd_ptr];
	assign head_data = entry_data[rd_ptr];

	always_ff @(posedge clk) begin
		if (push_ok) begin
			entry_write[wr_ptr] <= push_write;
			entry_address[wr_ptr] <= push_address;
			entry_mask[wr_ptr] <= push_mask;
			entry_data[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none or both
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/mem_controller.sv
`timescale 1ns/1ps
`default_nettype none

module mem_controller import mem_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic queue_empty,
	input wire logic head_write,
	input wire addr_t head_address,
	input wire mask_t head_mask,
	input wire line_t head_data,
	output logic queue_pop,
	input wire logic mem_available,
	output logic mem_read,
	output logic mem_write,
	output addr_t mem_address,
	output mask_t mem_mask,
	output line_t mem_data,
	output addr_t written_max
);

	ctrl_state_t state;
	logic issue_now;

	// strobes are registered, so mem_available never loops back through them
	assign issue_now = (state == CTRL_ISSUE) && mem_available;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= CTRL_IDLE;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			queue_pop <= 1'b0;
		end else begin
			mem_read <= 1'b0; // strobes last one cycle
			mem_write <= 1'b0;
			queue_pop <= 1'b0;
			case (state)
				CTRL_IDLE: begin
					if (!queue_empty)
						state <= CTRL_ISSUE;
				end
				CTRL_ISSUE: begin
					if (issue_now) begin
						mem_read <= ~head_write;
						mem_write <= head_write;
						queue_pop <= 1'b1;
						state <= CTRL_BUSY;
					end
				end
				CTRL_BUSY: begin
					// low while the strobe is present, high again once memory is done
					if (mem_available)
						state <= CTRL_IDLE;
				end
				default: state <= CTRL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue_now) begin
			mem_address <= head_address;
			mem_mask <= head_mask;
			mem_data <= head_data;
		end
	end

	// high-water mark of written lines, I/O window excluded
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			written_max <= '0;
		else if (mem_write && (mem_address > written_max) && (mem_address < IO_BASE_ADDR))
			written_max <= mem_address;
	end

endmodule

`default_nettype wire

//--- source/memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module memory_model import mem_pkg::*; #(
	parameter int unsigned MEM_LINES = 1024,
	parameter int unsigned ACCESS_DELAY = 3
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic mem_read,
	input wire logic mem_write,
	input wire addr_t mem_address,
	input wire mask_t mem_mask,
	input wire line_t mem_data,
	output logic mem_available,
	input wire logic resp_space,
	output logic resp_push,
	output addr_t resp_push_address,
	output line_t resp_push_data
);

	localparam int unsigned INDEX_WIDTH = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;
	localparam int unsigned DELAY_WIDTH = (ACCESS_DELAY > 0) ? $clog2(ACCESS_DELAY + 1) : 1;

	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [DELAY_WIDTH-1:0] delay_t;

	line_t lines [MEM_LINES];

	mem_state_t state;
	delay_t delay;
	logic was_read;
	addr_t line_address; // request address, offset cleared
	logic strobe;
	logic read_done;

	function automatic index_t line_of(addr_t address);
		return index_t'((address >> OFFSET_WIDTH) % MEM_LINES);
	endfunction

	initial begin
		for (int i = 0; i < MEM_LINES; i++)
			lines[i] = '0;
	end

	assign strobe = mem_read | mem_write;
	assign mem_available = (state == MEM_IDLE) && !strobe;
	// read response leaves only when the buffer has room
	assign read_done = (state == MEM_WAITING) && (delay == '0) && was_read && resp_space;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= MEM_IDLE;
			delay <= '0;
			was_read <= 1'b0;
			resp_push <= 1'b0;
		end else begin
			resp_push <= 1'b0;
			case (state)
				MEM_IDLE: begin
					if (strobe) begin
						state <= MEM_WAITING;
						was_read <= mem_read;
						delay <= delay_t'(ACCESS_DELAY);
					end
				end
				MEM_WAITING: begin
					if (delay != '0) begin
						delay <= delay - 1'b1;
					end else if (!was_read) begin
						state <= MEM_IDLE; // write already stored
					end else if (read_done) begin
						resp_push <= 1'b1;
						state <= MEM_IDLE;
					end
				end
				default: state <= MEM_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == MEM_IDLE && strobe)
			line_address <= mem_address & ~addr_t'(LINE_BYTES - 1);
		if (state == MEM_IDLE && mem_write) begin
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (mem_mask[b])
					lines[line_of(mem_address)][b*8 +: 8] <= mem_data[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (read_done) begin
			resp_push_address <= line_address;
			resp_push_data <= lines[line_of(line_address)];
		end
	end

endmodule

`default_nettype wire

//--- source/response_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module response_buffer import mem_pkg::*; #(
	parameter int unsigned RESP_DEPTH = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic push,
	input wire addr_t push_address,
	input wire line_t push_data,
	output logic space,
	input wire logic accept,
	output logic valid,
	output addr_t head_address,
	output line_t head_data
);

	localparam int unsigned PTR_WIDTH = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
	localparam int unsigned COUNT_WIDTH = $clog2(RESP_DEPTH + 1);

	addr_t entry_address [RESP_DEPTH];
	line_t entry_data [RESP_DEPTH];

	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic push_ok;
	logic pop_ok;

	assign space = (count != COUNT_WIDTH'(RESP_DEPTH));
	assign valid = (count != '0);
	assign push_ok = push & space;
	assign pop_ok = valid & accept;
	assign head_address = entry_address[rd_ptr];
	assign head_data = entry_data[rd_ptr];

	always_ff @(posedge clk) begin
		if (push_ok) begin
			entry_address[wr_ptr] <= push_address;
			entry_data[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !push_ok)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/memory_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memory_subsystem import mem_pkg::*; #(
	parameter int unsigned MEM_LINES = 1024,
	parameter int unsigned ACCESS_DELAY = 3,
	parameter int unsigned QUEUE_DEPTH = 4,
	parameter int unsigned RESP_DEPTH = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic req_valid,
	input wire logic req_write,
	input wire addr_t req_address,
	input wire mask_t req_mask,
	input wire line_t req_data,
	output logic req_ready,
	output logic resp_valid,
	output addr_t resp_address,
	output line_t resp_data,
	input wire logic resp_accept,
	output addr_t written_max
);

	logic queue_empty;
	logic queue_pop;
	logic head_write;
	addr_t head_address;
	mask_t head_mask;
	line_t head_data;

	logic mem_read;
	logic mem_write;
	logic mem_available;
	addr_t mem_address;
	mask_t mem_mask;
	line_t mem_data;

	logic resp_push;
	logic resp_space;
	addr_t resp_push_address;
	line_t resp_push_data;

	request_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_request_queue (
		.clk(clk), .reset(reset),
		.push(req_valid), .push_write(req_write), .push_address(req_address),
		.push_mask(req_mask), .push_data(req_data),
		.pop(queue_pop), .empty(queue_empty), .ready(req_ready),
		.head_write(head_write), .head_address(head_address),
		.head_mask(head_mask), .head_data(head_data)
	);

	mem_controller u_mem_controller (
		.clk(clk), .reset(reset),
		.queue_empty(queue_empty), .head_write(head_write), .head_address(head_address),
		.head_mask(head_mask), .head_data(head_data), .queue_pop(queue_pop),
		.mem_available(mem_available), .mem_read(mem_read), .mem_write(mem_write),
		.mem_address(mem_address), .mem_mask(mem_mask), .mem_data(mem_data),
		.written_max(written_max)
	);

	memory_model #(.MEM_LINES(MEM_LINES), .ACCESS_DELAY(ACCESS_DELAY)) u_memory_model (
		.clk(clk), .reset(reset),
		.mem_read(mem_read), .mem_write(mem_write), .mem_address(mem_address),
		.mem_mask(mem_mask), .mem_data(mem_data), .mem_available(mem_available),
		.resp_space(resp_space), .resp_push(resp_push),
		.resp_push_address(resp_push_address), .resp_push_data(resp_push_data)
	);

	response_buffer #(.RESP_DEPTH(RESP_DEPTH)) u_response_buffer (
		.clk(clk), .reset(reset),
		.push(resp_push), .push_address(resp_push_address), .push_data(resp_push_data),
		.space(resp_space), .accept(resp_accept), .valid(resp_valid),
		.head_address(resp_address), .head_data(resp_data)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int unsigned HALF_PERIOD = 20,
	parameter int unsigned RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk; // 40 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/tb_memory_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory_subsystem import mem_pkg::*; ();

	localparam int unsigned MEM_LINES = 1024;
	localparam int unsigned ACCESS_DELAY = 3;
	localparam int unsigned QUEUE_DEPTH = 4;
	localparam int unsigned RESP_DEPTH = 2;
	localparam logic [31:0] SEED = 32'ha632c85b;
	localparam int unsigned WAIT_LIMIT = 200; // cycles per wait

	logic clk;
	logic reset;
	logic req_valid;
	logic req_write;
	addr_t req_address;
	mask_t req_mask;
	line_t req_data;
	logic req_ready;
	logic resp_valid;
	addr_t resp_address;
	line_t resp_data;
	logic resp_accept;
	addr_t written_max;

	logic [31:0] rng_state;
	line_t shadow [MEM_LINES];
	addr_t expect_address [$]; // outstanding reads, oldest first
	line_t expect_data [$];

	tb_clock clock_gen (.clk(clk), .reset(reset));

	memory_subsystem #(
		.MEM_LINES(MEM_LINES), .ACCESS_DELAY(ACCESS_DELAY),
		.QUEUE_DEPTH(QUEUE_DEPTH), .RESP_DEPTH(RESP_DEPTH)
	) dut (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_write(req_write), .req_address(req_address),
		.req_mask(req_mask), .req_data(req_data), .req_ready(req_ready),
		.resp_valid(resp_valid), .resp_address(resp_address), .resp_data(resp_data),
		.resp_accept(resp_accept), .written_max(written_max)
	);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic line_t random_line();
		line_t value;
		for (int w = 0; w < 4; w++)
			value[w*32 +: 32] = next_random();
		return value;
	endfunction

	task automatic stop_with_error(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(input line_t got, input line_t want, input string what);
		if (got !== want)
			stop_with_error($sformatf("CHECK FAILED at %0t: %s, got %h expected %h",
				$time, what, got, want));
	endtask

	function automatic int line_index(addr_t address);
		return int'((address >> OFFSET_WIDTH) % MEM_LINES);
	endfunction

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_with_error("timed out waiting for req_ready");
		end while (!req_ready);
	endtask

	task automatic wait_response();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_with_error("timed out waiting for resp_valid");
		end while (!resp_valid);
	endtask

	task automatic send_request(input logic write, input addr_t address, input mask_t mask,
			input line_t data);
		int index;
		index = line_index(address);
		wait_ready();
		@(posedge clk);
		req_valid <= 1'b1;
		req_write <= write;
		req_address <= address;
		req_mask <= mask;
		req_data <= data;
		@(posedge clk);
		req_valid <= 1'b0;
		if (write) begin
			for (int b = 0; b < LINE_BYTES; b++)
				if (mask[b])
					shadow[index][b*8 +: 8] = data[b*8 +: 8];
		end else begin
			expect_address.push_back({address[31:OFFSET_WIDTH], OFFSET_WIDTH'(0)}); // line aligned
			expect_data.push_back(shadow[index]);
		end
	endtask

	task automatic receive_response();
		addr_t want_address;
		line_t want_data;
		if (expect_address.size() == 0)
			stop_with_error("a response was awaited with no read outstanding");
		want_address = expect_address.pop_front();
		want_data = expect_data.pop_front();
		wait_response();
		check(line_t'(resp_address), line_t'(want_address), "response address");
		check(resp_data, want_data, "response data");
		@(posedge clk);
		resp_accept <= 1'b1;
		@(posedge clk);
		resp_accept <= 1'b0;
	endtask

	task automatic reset_values();
		@(negedge clk);
		check(line_t'(req_ready), line_t'(1'b1), "req_ready after reset");
		check(line_t'(resp_valid), line_t'(1'b0), "resp_valid after reset");
		check(line_t'(written_max), '0, "written_max after reset");
	endtask

	task automatic unaligned_read();
		send_request(1'b1, 32'h0000_1230, 16'hffff, random_line());
		send_request(1'b0, 32'h0000_1237, '0, '0);
		receive_response();
	endtask

	task automatic partial_write_merge();
		send_request(1'b1, 32'h0000_2a40, 16'h00ff, random_line());
		send_request(1'b1, 32'h0000_2a44, 16'h0ff0, random_line());
		send_request(1'b1, 32'h0000_2a48, 16'h8001, random_line());
		send_request(1'b0, 32'h0000_2a4c, '0, '0);
		receive_response();
	endtask

	task automatic backpressure_order();
		int accepted;
		int stalled;
		accepted = 0;
		stalled = 0;
		while (stalled < 40) begin // stop once ready stays low
			@(negedge clk);
			if (req_ready && accepted < 20) begin
				send_request(1'b0, addr_t'(32'h0000_0400 + accepted * LINE_BYTES), '0, '0);
				accepted++;
				stalled = 0;
			end else begin
				stalled++;
			end
		end
		check(line_t'(req_ready), line_t'(1'b0), "req_ready under back-pressure");
		check(line_t'(accepted <= QUEUE_DEPTH + RESP_DEPTH + 1), line_t'(1'b1),
			"reads accepted under back-pressure");
		repeat (accepted) receive_response();
	endtask

	task automatic random_traffic();
		logic [31:0] r;
		addr_t address;
		for (int i = 0; i < 200; i++) begin
			r = next_random();
			address = addr_t'(next_random() % (MEM_LINES * LINE_BYTES));
			if (r[0]) begin
				send_request(1'b1, address, mask_t'(next_random()), random_line());
			end else begin
				send_request(1'b0, address, '0, '0);
				wait_response();
				repeat (r[3:2]) @(posedge clk); // accept gap
				receive_response();
			end
		end
	endtask

	task automatic high_water_mark();
		send_request(1'b1, 32'h0010_0000, 16'hffff, random_line());
		send_request(1'b1, 32'h0020_0040, 16'hffff, random_line());
		send_request(1'b1, 32'h0010_0800, 16'hffff, random_line());
		send_request(1'b1, 32'h8000_1000, 16'hffff, random_line()); // I/O window
		send_request(1'b0, 32'h0000_0000, '0, '0); // flush behind the writes
		receive_response();
		@(negedge clk);
		check(line_t'(written_max), line_t'(32'h0020_0040), "written_max");
	endtask

	initial begin
		int cycles;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_address = '0;
		req_mask = '0;
		req_data = '0;
		resp_accept = 1'b0;
		rng_state = SEED;
		for (int i = 0; i < MEM_LINES; i++)
			shadow[i] = '0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_with_error("reset was never released");
		end while (reset);
		reset_values();
		unaligned_read();
		partial_write_merge();
		backpressure_order();
		random_traffic();
		high_water_mark();
		if (expect_address.size() == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("some read requests were never answered");
			$display("Something failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- compile.f
source/mem_pkg.sv
source/request_queue.sv
source/mem_controller.sv
source/memory_model.sv
source/response_buffer.sv
source/memory_subsystem.sv
tests/tb_clock.sv
tests/tb_memory_subsystem.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run into sim.log, then look for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_memory_subsystem -f compile.f \
	-o sim_memory_subsystem || { echo "build failed"; exit 1; }
./obj_dir/sim_memory_subsystem > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Everything OK" sim.log || { echo "FAIL: run ended without a result"; exit 1; }
echo "PASS"
